// File: design/fmap_consts.svh
`ifndef FMAP_CONSTS_SVH
`define FMAP_CONSTS_SVH

// map geometry
`define FMAP_DIM        8   // pixels per side
`define FMAP_CHANNELS   32  // channel count
`define FMAP_ORIGIN_MAX 6   // view is 2x2, so origin stops one short of the edge

// data widths
`define PIX_W 8   // one pixel
`define OUT_W 14  // output word, pixel zero-extended
`define OP_W  4   // host op code

// host op codes
`define OP_LOAD     4'd0  // load whole map
`define OP_RIGHT    4'd1  // origin x+1
`define OP_LEFT     4'd2  // origin x-1
`define OP_UP       4'd3  // origin y-1
`define OP_DOWN     4'd4  // origin y+1
`define OP_WIN_DOWN 4'd5  // halve channel window
`define OP_WIN_UP   4'd6  // double channel window
`define OP_DISPLAY  4'd7  // stream the view

// read address to output register, in cycles
`define READ_LAT 2

`endif

// File: design/fmap_pkg.sv
`default_nettype none

`include "fmap_consts.svh"

package fmap_pkg;

	localparam int COORD_W = $clog2(`FMAP_DIM);       // 3 bits for 0..7
	localparam int CHAN_W  = $clog2(`FMAP_CHANNELS);  // 5 bits for 0..31
	localparam int ADDR_W  = CHAN_W + 2 * COORD_W;    // {chan, y, x}

	typedef logic [COORD_W-1:0] coord_t;     // x or y
	typedef logic [CHAN_W-1:0]  chan_t;      // channel index
	typedef logic [ADDR_W-1:0]  addr_t;      // chan*64 + y*8 + x
	typedef logic [`PIX_W-1:0]  pixel_t;
	typedef logic [`OUT_W-1:0]  out_data_t;
	typedef logic [`OP_W-1:0]   op_t;

	typedef enum logic [2:0] {
		START,    // one cycle after reset
		WAIT_OP,  // op_ready high
		LOAD,     // taking map bytes
		DISPLAY,  // scanner issuing reads
		DRAIN,    // last beats leaving the read pipe
		FINISH    // one idle cycle before next op
	} ctrl_state_t;

	typedef enum logic [1:0] {
		WIN_8  = 2'd0,
		WIN_16 = 2'd1,
		WIN_32 = 2'd2
	} chan_win_t;

endpackage

`default_nettype wire

// File: design/op_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "fmap_consts.svh"

module op_decoder import fmap_pkg::*; (
	input  wire  i_clk,
	input  wire  i_rst_n,
	input  logic i_op_valid,
	input  op_t  i_op_mode,
	input  logic i_load_done,    // last map byte written
	input  logic i_scan_last,    // scanner on its final address
	input  logic i_pipe_empty,   // no beat left in result stage
	output logic o_op_ready,
	output logic o_load_start,
	output logic o_scan_start,
	output logic o_shift_right,
	output logic o_shift_left,
	output logic o_shift_up,
	output logic o_shift_down,
	output logic o_win_down,
	output logic o_win_up,
	output logic o_in_ready
);

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	logic        op_take;

	assign o_op_ready = (state == WAIT_OP);
	assign o_in_ready = (state == LOAD);       // loader is active for exactly these cycles
	assign op_take    = o_op_ready & i_op_valid;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= START;
		end else begin
			state <= state_nxt;
		end
	end

	// strobes fire in the cycle the op is taken, so the effect lands on the next edge
	always_comb begin
		state_nxt     = state;
		o_load_start  = 1'b0;
		o_scan_start  = 1'b0;
		o_shift_right = 1'b0;
		o_shift_left  = 1'b0;
		o_shift_up    = 1'b0;
		o_shift_down  = 1'b0;
		o_win_down    = 1'b0;
		o_win_up      = 1'b0;
		case (state)
			START:   state_nxt = WAIT_OP;
			WAIT_OP: begin
				if (op_take) begin
					state_nxt = FINISH;   // shifts, window ops and unused codes
					case (i_op_mode)
						`OP_LOAD: begin
							o_load_start = 1'b1;
							state_nxt    = LOAD;
						end
						`OP_RIGHT:    o_shift_right = 1'b1;
						`OP_LEFT:     o_shift_left  = 1'b1;
						`OP_UP:       o_shift_up    = 1'b1;
						`OP_DOWN:     o_shift_down  = 1'b1;
						`OP_WIN_DOWN: o_win_down    = 1'b1;
						`OP_WIN_UP:   o_win_up      = 1'b1;
						`OP_DISPLAY: begin
							o_scan_start = 1'b1;
							state_nxt    = DISPLAY;
						end
						default: ;            // 8..15 accepted and dropped
					endcase
				end
			end
			LOAD:    if (i_load_done) state_nxt = FINISH;
			DISPLAY: if (i_scan_last) state_nxt = DRAIN;
			DRAIN:   if (i_pipe_empty) state_nxt = FINISH;  // two beats still in flight on entry
			FINISH:  state_nxt = WAIT_OP;
			default: state_nxt = START;
		endcase
	end

endmodule

`default_nettype wire

// File: design/view_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "fmap_consts.svh"

module view_regs import fmap_pkg::*; (
	input  wire       i_clk,
	input  wire       i_rst_n,
	input  logic      i_shift_right,
	input  logic      i_shift_left,
	input  logic      i_shift_up,
	input  logic      i_shift_down,
	input  logic      i_win_down,
	input  logic      i_win_up,
	output coord_t    o_origin_x,
	output coord_t    o_origin_y,
	output chan_win_t o_chan_win
);

	localparam coord_t ORIGIN_MAX = coord_t'(`FMAP_ORIGIN_MAX);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_origin_x <= '0;
			o_origin_y <= '0;
			o_chan_win <= WIN_32;   // full window after reset
		end else begin
			// x axis, right is +1
			if (i_shift_right && o_origin_x != ORIGIN_MAX) o_origin_x <= o_origin_x + 1'b1;
			else if (i_shift_left && o_origin_x != '0) o_origin_x <= o_origin_x - 1'b1;

			// y axis, down is +1, up is -1
			if (i_shift_down && o_origin_y != ORIGIN_MAX) o_origin_y <= o_origin_y + 1'b1;
			else if (i_shift_up && o_origin_y != '0) o_origin_y <= o_origin_y - 1'b1;

			// window steps 8 <-> 16 <-> 32, stuck at both ends
			if (i_win_up) begin
				case (o_chan_win)
					WIN_8:   o_chan_win <= WIN_16;
					default: o_chan_win <= WIN_32;
				endcase
			end else if (i_win_down) begin
				case (o_chan_win)
					WIN_32:  o_chan_win <= WIN_16;
					default: o_chan_win <= WIN_8;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: design/fmap_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "fmap_consts.svh"

module fmap_loader import fmap_pkg::*; (
	input  wire    i_clk,
	input  wire    i_rst_n,
	input  logic   i_load_start,   // one cycle, from decoder
	input  logic   i_in_valid,
	input  pixel_t i_in_data,
	output logic   o_mem_we,
	output addr_t  o_mem_waddr,
	output pixel_t o_mem_wdata,
	output logic   o_load_done     // with the final write
);

	localparam addr_t LAST_ADDR = addr_t'(`FMAP_DIM * `FMAP_DIM * `FMAP_CHANNELS - 1);

	logic  active;
	addr_t waddr;   // host order is x, then y, then channel, so a plain count is the address

	assign o_mem_we    = active & i_in_valid;   // idle input just pauses
	assign o_mem_waddr = waddr;
	assign o_mem_wdata = i_in_data;
	assign o_load_done = o_mem_we & (waddr == LAST_ADDR);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			active <= 1'b0;
			waddr  <= '0;
		end else if (i_load_start) begin
			active <= 1'b1;
			waddr  <= '0;
		end else if (o_mem_we) begin
			waddr <= waddr + 1'b1;              // wraps to 0 after the last byte
			if (o_load_done) active <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: design/fmap_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "fmap_consts.svh"

module fmap_mem import fmap_pkg::*; (
	input  wire    i_clk,
	input  logic   i_we,
	input  addr_t  i_waddr,
	input  pixel_t i_wdata,
	input  addr_t  i_raddr,
	output pixel_t o_rdata     // one cycle after i_raddr
);

	localparam int DEPTH = `FMAP_DIM * `FMAP_DIM * `FMAP_CHANNELS;

	pixel_t mem [0:DEPTH-1];

	always_ff @(posedge i_clk) begin
		if (i_we) begin
			mem[i_waddr] <= i_wdata;
		end
		o_rdata <= mem[i_raddr];   // read-old on a same-address collision
	end

endmodule

`default_nettype wire

// File: design/view_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module view_scanner import fmap_pkg::*; (
	input  wire       i_clk,
	input  wire       i_rst_n,
	input  logic      i_scan_start,   // one cycle, from decoder
	input  coord_t    i_origin_x,
	input  coord_t    i_origin_y,
	input  chan_win_t i_chan_win,
	output addr_t     o_raddr,
	output logic      o_rd_valid,
	output logic      o_scan_last
);

	logic   active;
	coord_t x_cnt;
	coord_t y_cnt;
	chan_t  ch_cnt;
	chan_t  ch_last;   // window size minus 1
	coord_t x_end;
	coord_t y_end;
	logic   x_wrap;
	logic   y_wrap;
	logic   ch_wrap;

	always_comb begin
		case (i_chan_win)
			WIN_8:   ch_last = chan_t'(7);
			WIN_16:  ch_last = chan_t'(15);
			default: ch_last = chan_t'(31);
		endcase
	end

	// origin tops out at 6, so +1 never overflows
	assign x_end   = i_origin_x + 1'b1;
	assign y_end   = i_origin_y + 1'b1;
	assign x_wrap  = (x_cnt == x_end);
	assign y_wrap  = (y_cnt == y_end);
	assign ch_wrap = (ch_cnt == ch_last);

	assign o_raddr     = {ch_cnt, y_cnt, x_cnt};   // chan*64 + y*8 + x
	assign o_rd_valid  = active;
	assign o_scan_last = active & x_wrap & y_wrap & ch_wrap;

	// x fastest, then y, then channel; one address per cycle, no gaps
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			active <= 1'b0;
			x_cnt  <= '0;
			y_cnt  <= '0;
			ch_cnt <= '0;
		end else if (i_scan_start) begin
			active <= 1'b1;
			x_cnt  <= i_origin_x;
			y_cnt  <= i_origin_y;
			ch_cnt <= '0;
		end else if (active) begin
			if (x_wrap) begin
				x_cnt <= i_origin_x;
				if (y_wrap) begin
					y_cnt <= i_origin_y;
					if (ch_wrap) active <= 1'b0;   // final address just issued
					else ch_cnt <= ch_cnt + 1'b1;
				end else begin
					y_cnt <= y_cnt + 1'b1;
				end
			end else begin
				x_cnt <= x_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/result_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "fmap_consts.svh"

module result_stage import fmap_pkg::*; (
	input  wire       i_clk,
	input  wire       i_rst_n,
	input  logic      i_rd_valid,   // paired with the read address
	input  pixel_t    i_rd_data,    // memory output, one cycle later
	output logic      o_out_valid,
	output out_data_t o_out_data,
	output logic      o_pipe_empty
);

	logic [`READ_LAT-1:0] valid_sr;   // bit 0 lines up with i_rd_data

	assign o_out_valid  = valid_sr[`READ_LAT-1];
	assign o_pipe_empty = ~|valid_sr;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			valid_sr <= '0;
		end else begin
			valid_sr <= {valid_sr[`READ_LAT-2:0], i_rd_valid};
		end
	end

	// capture only when the memory word is real
	always_ff @(posedge i_clk) begin
		if (valid_sr[`READ_LAT-2]) begin
			o_out_data <= out_data_t'(i_rd_data);   // zero-extend
		end
	end

endmodule

`default_nettype wire

// File: design/fmap_top.sv
`timescale 1ns/1ps
`default_nettype none

module fmap_top import fmap_pkg::*; (
	input  wire       i_clk,
	input  wire       i_rst_n,
	input  logic      i_op_valid,
	input  op_t       i_op_mode,
	output logic      o_op_ready,
	input  logic      i_in_valid,
	input  pixel_t    i_in_data,
	output logic      o_in_ready,
	output logic      o_out_valid,
	output out_data_t o_out_data
);

	// decoder strobes
	logic load_start;
	logic scan_start;
	logic shift_right;
	logic shift_left;
	logic shift_up;
	logic shift_down;
	logic win_down;
	logic win_up;

	// handshakes back to the decoder
	logic load_done;
	logic scan_last;
	logic pipe_empty;

	// view state
	coord_t    origin_x;
	coord_t    origin_y;
	chan_win_t chan_win;

	// memory ports
	logic   mem_we;
	addr_t  mem_waddr;
	pixel_t mem_wdata;
	addr_t  mem_raddr;
	pixel_t rd_data;
	logic   rd_valid;

	op_decoder op_decoder_i (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_op_valid(i_op_valid), .i_op_mode(i_op_mode),
		.i_load_done(load_done), .i_scan_last(scan_last), .i_pipe_empty(pipe_empty),
		.o_op_ready(o_op_ready), .o_load_start(load_start), .o_scan_start(scan_start),
		.o_shift_right(shift_right), .o_shift_left(shift_left),
		.o_shift_up(shift_up), .o_shift_down(shift_down),
		.o_win_down(win_down), .o_win_up(win_up), .o_in_ready(o_in_ready)
	);

	view_regs view_regs_i (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_shift_right(shift_right), .i_shift_left(shift_left),
		.i_shift_up(shift_up), .i_shift_down(shift_down),
		.i_win_down(win_down), .i_win_up(win_up),
		.o_origin_x(origin_x), .o_origin_y(origin_y), .o_chan_win(chan_win)
	);

	fmap_loader fmap_loader_i (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_load_start(load_start), .i_in_valid(i_in_valid), .i_in_data(i_in_data),
		.o_mem_we(mem_we), .o_mem_waddr(mem_waddr), .o_mem_wdata(mem_wdata),
		.o_load_done(load_done)
	);

	fmap_mem fmap_mem_i (
		.i_clk(i_clk), .i_we(mem_we), .i_waddr(mem_waddr), .i_wdata(mem_wdata),
		.i_raddr(mem_raddr), .o_rdata(rd_data)
	);

	view_scanner view_scanner_i (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_scan_start(scan_start),
		.i_origin_x(origin_x), .i_origin_y(origin_y), .i_chan_win(chan_win),
		.o_raddr(mem_raddr), .o_rd_valid(rd_valid), .o_scan_last(scan_last)
	);

	result_stage result_stage_i (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_rd_valid(rd_valid), .i_rd_data(rd_data),
		.o_out_valid(o_out_valid), .o_out_data(o_out_data), .o_pipe_empty(pipe_empty)
	);

endmodule

`default_nettype wire

// File: sim/fmap_tb_tasks.svh
// one edge plus settle time; inputs are driven and outputs read here
task automatic step_cycle();
	@(posedge i_clk);
	#1;
endtask

task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
	checks++;
	if (actual !== expected) begin   // x or z on the DUT side also fails
		errors++;
		$display("error %s expected %0d actual %0d", name, expected, actual);
	end
endtask

task automatic wait_op_ready(input string name);
	int cycles;
	cycles = 0;
	while (!o_op_ready && cycles < TIMEOUT) begin
		step_cycle();
		cycles++;
	end
	if (!o_op_ready) begin
		errors++;
		$display("%s: o_op_ready stayed low for %0d cycles", name, TIMEOUT);
	end
endtask

// valid held for the single cycle in which the op is taken
task automatic send_op(input string name, input op_t op);
	wait_op_ready(name);
	i_op_valid = 1'b1;
	i_op_mode  = op;
	step_cycle();
	i_op_valid = 1'b0;
	update_model(op);
endtask

task automatic run_display(input string name);
	out_data_t beats[$];
	int        exp_beats;
	int        first;
	int        last;
	int        cycles;
	exp_beats = 4 * model_win;   // four view pixels per channel in the window
	first     = -1;
	last      = -1;
	cycles    = 0;
	send_op(name, `OP_DISPLAY);
	while (!o_op_ready && cycles < TIMEOUT) begin
		if (o_out_valid) begin
			beats.push_back(o_out_data);
			if (first < 0) first = cycles;   // cycle of first beat
			last = cycles;
		end
		step_cycle();
		cycles++;
	end
	wait_op_ready(name);   // reports if the decoder never came back
	check_value({name, " beat count"}, exp_beats, beats.size());
	if (beats.size() > 0 && last - first + 1 != beats.size()) begin
		errors++;
		$display("%s: o_out_valid dropped in the middle of the display", name);
	end
	foreach (beats[i]) begin
		if (i < exp_beats) begin
			check_value($sformatf("%s beat %0d", name, i), expected_pixel(i), beats[i]);
		end
	end
endtask

task automatic finish_test(input string name, input int err_start);
	tests++;
	$display("%s finished, %0d errors", name, errors - err_start);
endtask

task automatic test_reset();
	int err_start;
	err_start = errors;
	check_value("reset in_ready", 0, o_in_ready);
	check_value("reset out_valid", 0, o_out_valid);
	wait_op_ready("reset");
	finish_test("reset", err_start);
endtask

task automatic test_load_display();
	int   err_start;
	int   idx;
	int   cycles;
	logic take;
	err_start = errors;
	idx       = 0;
	cycles    = 0;
	send_op("load", `OP_LOAD);
	while (idx < MAP_BYTES && cycles < 4 * MAP_BYTES) begin
		take       = o_in_ready && ($random(seed) % 4 != 0);   // about one idle in four
		i_in_valid = take;
		i_in_data  = pixel_t'($random(seed));
		if (take) begin
			model_mem[idx] = i_in_data;   // bytes arrive in address order
			idx++;
		end
		step_cycle();
		cycles++;
	end
	i_in_valid = 1'b0;
	if (idx < MAP_BYTES) begin
		errors++;
		$display("load: only %0d of %0d bytes were taken", idx, MAP_BYTES);
	end
	wait_op_ready("load");
	check_value("load in_ready after load", 0, o_in_ready);
	run_display("load display");
	finish_test("load", err_start);
endtask

task automatic test_shift_view();
	int err_start;
	err_start = errors;
	repeat (8) send_op("shift", `OP_RIGHT);   // stops at x 6
	repeat (2) send_op("shift", `OP_DOWN);
	run_display("shift to 6 2");
	repeat (8) send_op("shift", `OP_LEFT);
	repeat (4) send_op("shift", `OP_UP);
	run_display("shift back to 0 0");
	finish_test("shift", err_start);
endtask

task automatic test_window_scale();
	int err_start;
	err_start = errors;
	repeat (3) send_op("window", `OP_WIN_DOWN);   // third one held at 8
	run_display("window down");
	send_op("window", `OP_WIN_UP);
	run_display("window up");
	finish_test("window", err_start);
endtask

task automatic test_ignored_ops();
	int   err_start;
	int   cycles;
	logic seen;
	err_start = errors;
	for (int code = 10; code <= 15; code += 5) begin
		send_op("ignored", op_t'(code));
		seen   = 1'b0;
		cycles = 0;
		while (!o_op_ready && cycles < TIMEOUT) begin
			seen = seen | o_out_valid | o_in_ready;   // any activity is wrong
			step_cycle();
			cycles++;
		end
		wait_op_ready("ignored");
		check_value($sformatf("ignored op %0d activity", code), 0, seen);
	end
	finish_test("ignored", err_start);
endtask

// File: sim/fmap_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fmap_consts.svh"

module fmap_tb import fmap_pkg::*; ();

	localparam int MAP_BYTES = `FMAP_DIM * `FMAP_DIM * `FMAP_CHANNELS;
	localparam int TIMEOUT   = 400;   // cycles allowed for one op to complete

	logic      i_clk;
	logic      i_rst_n;
	logic      i_op_valid;
	op_t       i_op_mode;
	logic      o_op_ready;
	logic      i_in_valid;
	pixel_t    i_in_data;
	logic      o_in_ready;
	logic      o_out_valid;
	out_data_t o_out_data;

	pixel_t model_mem [0:MAP_BYTES-1];   // expected map contents
	int     model_x;                     // expected view origin
	int     model_y;
	int     model_win;                   // channels in the window
	integer seed;
	int     errors;
	int     checks;
	int     tests;

	fmap_top fmap_top_i (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_op_valid(i_op_valid), .i_op_mode(i_op_mode), .o_op_ready(o_op_ready),
		.i_in_valid(i_in_valid), .i_in_data(i_in_data), .o_in_ready(o_in_ready),
		.o_out_valid(o_out_valid), .o_out_data(o_out_data)
	);

	initial begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk;   // 40 ns period
	end

	// beats run channel by channel, each channel as y then x over the 2x2 view
	function automatic int expected_pixel(input int beat);
		int ch;
		int y;
		int x;
		ch = beat / 4;
		y  = model_y + (beat % 4) / 2;
		x  = model_x + beat % 2;
		return model_mem[ch * `FMAP_DIM * `FMAP_DIM + y * `FMAP_DIM + x];
	endfunction

	// origin clamps to 0..6, window doubles or halves between 8 and 32
	function automatic void update_model(input op_t op);
		case (op)
			`OP_RIGHT:    if (model_x < `FMAP_ORIGIN_MAX) model_x++;
			`OP_LEFT:     if (model_x > 0) model_x--;
			`OP_UP:       if (model_y > 0) model_y--;
			`OP_DOWN:     if (model_y < `FMAP_ORIGIN_MAX) model_y++;
			`OP_WIN_DOWN: if (model_win > 8) model_win = model_win / 2;
			`OP_WIN_UP:   if (model_win < `FMAP_CHANNELS) model_win = model_win * 2;
			default: ;   // load, display and unused codes leave the view alone
		endcase
	endfunction

	`include "fmap_tb_tasks.svh"

	initial begin
		i_rst_n    = 1'b0;
		i_op_valid = 1'b0;
		i_op_mode  = '0;
		i_in_valid = 1'b0;
		i_in_data  = '0;
		seed       = 32'h5783;
		model_x    = 0;
		model_y    = 0;
		model_win  = `FMAP_CHANNELS;   // window resets to full
		errors     = 0;
		checks     = 0;
		tests      = 0;
		repeat (5) @(posedge i_clk);
		#1;
		i_rst_n = 1'b1;                // released just after an edge
		test_reset();
		test_load_display();
		test_shift_view();
		test_window_scale();
		test_ignored_ops();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+design
+incdir+sim
design/fmap_pkg.sv
design/op_decoder.sv
design/view_regs.sv
design/fmap_loader.sv
design/fmap_mem.sv
design/view_scanner.sv
design/result_stage.sv
design/fmap_top.sv
sim/fmap_tb.sv
